// File: dispatch_pkg.sv
package dispatch_pkg;

    // ====================
    // widths
    // ====================
    localparam int INST_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 32;
    localparam int REG_WIDTH      = 32;
    localparam int INST_IDX_WIDTH = 5;
    localparam int REG_NUM        = 32;
    localparam int REG_IDX_WIDTH  = 5;
    // issue targets and write-back channels
    localparam int UNIT_NUM       = 5;
    localparam int WB_NUM         = 4;

    // mcause code for an illegal instruction
    localparam logic [31:0] MCAUSE_ILLEGAL_INSTR = 32'd2;

    // ====================
    // enums
    // ====================
    // rv32 major opcodes, inst[6:2]
    typedef enum logic [4:0] {
        OPC_LOAD     = 5'b00000,
        OPC_MISC_MEM = 5'b00011,
        OPC_OP_IMM   = 5'b00100,
        OPC_AUIPC    = 5'b00101,
        OPC_STORE    = 5'b01000,
        OPC_OP       = 5'b01100,
        OPC_LUI      = 5'b01101,
        OPC_BRANCH   = 5'b11000,
        OPC_JALR     = 5'b11001,
        OPC_JAL      = 5'b11011,
        OPC_SYSTEM   = 5'b11100
    } opcode_e;

    // value doubles as bit index into issue_vld / issue_rdy
    typedef enum logic [2:0] {
        UNIT_ALU  = 3'd0,
        UNIT_LSU  = 3'd1,
        UNIT_MEXT = 3'd2,
        UNIT_CSR  = 3'd3,
        UNIT_SPU  = 3'd4
    } unit_e;

    // ====================
    // structs
    // ====================
    typedef struct packed {
        logic [INST_WIDTH-1:0]     inst;
        logic [ADDR_WIDTH-1:0]     pc;
        logic [INST_IDX_WIDTH-1:0] tag;
    } fetch_t;

    typedef struct packed {
        logic [INST_WIDTH-1:0]     inst;
        logic [ADDR_WIDTH-1:0]     pc;
        logic [INST_IDX_WIDTH-1:0] tag;
        logic [REG_IDX_WIDTH-1:0]  rs1;
        logic [REG_IDX_WIDTH-1:0]  rs2;
        logic [REG_IDX_WIDTH-1:0]  rd;
        logic                      rd_en;
        logic [REG_WIDTH-1:0]      imm;
        unit_e                     unit;
    } dec_t;

    typedef struct packed {
        logic                      en;
        logic [REG_IDX_WIDTH-1:0]  idx;
        logic [REG_WIDTH-1:0]      data;
    } wb_t;

    typedef struct packed {
        logic [INST_WIDTH-1:0]     inst;
        logic [ADDR_WIDTH-1:0]     pc;
        logic [INST_IDX_WIDTH-1:0] tag;
        logic [REG_IDX_WIDTH-1:0]  rd;
        logic                      rd_en;
        logic [REG_WIDTH-1:0]      imm;
        logic [REG_WIDTH-1:0]      rs1_val;
        logic [REG_WIDTH-1:0]      rs2_val;
    } issue_t;

endpackage

// File: dispatch_top.sv
`timescale 1ns/1ps

module dispatch_top
    import dispatch_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    // fetch side
    input  logic                fetch_vld,
    input  fetch_t              fetch,
    output logic                fetch_rdy,
    // issue side, one valid/ready bit per unit
    output issue_t              issue,
    output logic [UNIT_NUM-1:0] issue_vld,
    input  logic [UNIT_NUM-1:0] issue_rdy,
    output logic                trap_en,
    output logic [31:0]         trap_cause,
    // write-back channels: lsu, alu, csr, mext
    input  wb_t                 wb [WB_NUM],
    output logic [63:0]         instret
);

    logic                 dec_vld;
    logic                 dec_rdy;
    dec_t                 dec;
    logic [REG_NUM-1:0]   lock;
    logic                 issue_fire;
    logic [REG_WIDTH-1:0] rs1_val;
    logic [REG_WIDTH-1:0] rs2_val;

    // ====================
    // decode stage
    // ====================
    inst_decoder u_dec (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_vld (fetch_vld),
        .fetch     (fetch),
        .fetch_rdy (fetch_rdy),
        .lock      (lock),
        .dec_vld   (dec_vld),
        .dec       (dec),
        .dec_rdy   (dec_rdy)
    );

    // ====================
    // unit routing
    // ====================
    // only the decoded unit sees valid
    always_comb begin
        issue_vld           = '0;
        issue_vld[dec.unit] = dec_vld;
    end

    // ready comes back from the same unit
    assign dec_rdy    = issue_rdy[dec.unit];
    assign issue_fire = dec_vld && dec_rdy;

    // shared payload for all units
    assign issue.inst    = dec.inst;
    assign issue.pc      = dec.pc;
    assign issue.tag     = dec.tag;
    assign issue.rd      = dec.rd;
    assign issue.rd_en   = dec.rd_en;
    assign issue.imm     = dec.imm;
    assign issue.rs1_val = rs1_val;
    assign issue.rs2_val = rs2_val;

    // every spu item is an illegal instruction now
    assign trap_en    = (dec.unit == UNIT_SPU);
    assign trap_cause = trap_en ? MCAUSE_ILLEGAL_INSTR : '0;

    // retired count, one per accepted fetch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instret <= 64'd0;
        end else if (fetch_vld && fetch_rdy) begin
            instret <= instret + 64'd1;
        end
    end

    // ====================
    // registers
    // ====================
    reg_scoreboard u_sb (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue_fire  (issue_fire),
        .issue_rd    (dec.rd),
        .issue_rd_en (dec.rd_en),
        .wb          (wb),
        .lock        (lock)
    );

    // operands read straight off the stage register
    reg_file u_rf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb      (wb),
        .rs1     (dec.rs1),
        .rs2     (dec.rs2),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

endmodule

// File: files.f
dispatch_pkg.sv
inst_decoder.sv
reg_scoreboard.sv
reg_file.sv
dispatch_top.sv
tb_dispatch.sv

// File: inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import dispatch_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fetch_vld,
    input  fetch_t             fetch,
    output logic               fetch_rdy,
    input  logic [REG_NUM-1:0] lock,
    output logic               dec_vld,
    output dec_t               dec,
    input  logic               dec_rdy
);

    logic [INST_WIDTH-1:0]    w;
    opcode_e                  opcode;
    logic [REG_IDX_WIDTH-1:0] rs1;
    logic [REG_IDX_WIDTH-1:0] rs2;
    logic [REG_IDX_WIDTH-1:0] rd;
    unit_e                    unit;
    logic                     rd_en;
    logic                     use_rs1;
    logic                     use_rs2;
    logic [REG_WIDTH-1:0]     imm;
    logic                     hazard_lock;
    logic                     hazard_stage;
    logic                     run_q;
    logic                     accept;

    // field extraction from the incoming word
    assign w      = fetch.inst;
    assign opcode = opcode_e'(w[6:2]);
    assign rs1    = w[19:15];
    assign rs2    = w[24:20];
    assign rd     = w[11:7];

    // ====================
    // classification
    // ====================
    always_comb begin
        unit    = UNIT_SPU;
        rd_en   = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        imm     = '0;
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                unit    = UNIT_ALU;
                use_rs1 = 1'b0;
                imm     = {w[31:12], 12'b0};
            end
            OPC_JAL: begin
                unit    = UNIT_ALU;
                use_rs1 = 1'b0;
                imm     = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            OPC_JALR, OPC_OP_IMM, OPC_MISC_MEM: begin
                unit = UNIT_ALU;
                imm  = {{20{w[31]}}, w[31:20]};
            end
            OPC_BRANCH: begin
                unit    = UNIT_ALU;
                rd_en   = 1'b0;
                use_rs2 = 1'b1;
                imm     = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            OPC_LOAD: begin
                unit = UNIT_LSU;
                imm  = {{20{w[31]}}, w[31:20]};
            end
            OPC_STORE: begin
                unit    = UNIT_LSU;
                rd_en   = 1'b0;
                use_rs2 = 1'b1;
                imm     = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            OPC_OP: begin
                // funct7[0] marks the M extension
                unit    = w[25] ? UNIT_MEXT : UNIT_ALU;
                use_rs2 = 1'b1;
            end
            OPC_SYSTEM: begin
                unit  = UNIT_CSR;
                // ecall/ebreak/xret write nothing
                rd_en = (w[14:12] != 3'b000);
                imm   = {{20{w[31]}}, w[31:20]};
            end
            default: begin
                // illegal, trap through the spu
                rd_en = 1'b0;
            end
        endcase
    end

    // ====================
    // hazard hold
    // ====================
    // outstanding write-back on any used register
    assign hazard_lock = (use_rs1 && lock[rs1]) || (use_rs2 && lock[rs2]) || (rd_en && lock[rd]);

    // producer still in the stage, its lock is not set yet
    assign hazard_stage = dec_vld && dec.rd_en && (dec.rd != '0)
                       && ((use_rs1 && (rs1 == dec.rd))
                       ||  (use_rs2 && (rs2 == dec.rd))
                       ||  (rd_en   && (rd  == dec.rd)));

    // run_q keeps fetch closed until the first edge out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    assign fetch_rdy = run_q && (!dec_vld || dec_rdy) && !hazard_lock && !hazard_stage;
    assign accept    = fetch_vld && fetch_rdy;

    // single stage register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_vld <= 1'b0;
        end else if (accept) begin
            dec_vld <= 1'b1;
        end else if (dec_rdy) begin
            dec_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec.inst  <= fetch.inst;
            dec.pc    <= fetch.pc;
            dec.tag   <= fetch.tag;
            dec.rs1   <= rs1;
            dec.rs2   <= rs2;
            dec.rd    <= rd;
            dec.rd_en <= rd_en;
            dec.imm   <= imm;
            dec.unit  <= unit;
        end
    end

    // offer held until the unit takes it
    a_dec_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dec_vld && !dec_rdy |=> dec_vld && $stable(dec));

endmodule

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file
    import dispatch_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  wb_t                      wb [WB_NUM],
    input  logic [REG_IDX_WIDTH-1:0] rs1,
    input  logic [REG_IDX_WIDTH-1:0] rs2,
    output logic [REG_WIDTH-1:0]     rs1_val,
    output logic [REG_WIDTH-1:0]     rs2_val
);

    logic [REG_WIDTH-1:0] regs [REG_NUM];

    // ====================
    // write ports
    // ====================
    // entry 0 is never written
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int j = 0; j < WB_NUM; j++) begin
                if (wb[j].en && (wb[j].idx != '0)) begin
                    regs[wb[j].idx] <= wb[j].data;
                end
            end
        end
    end

    // ====================
    // read ports
    // ====================
    // no bypass, a write shows up one cycle later
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    // one write per register per cycle, the lock allows a single producer
    for (genvar a = 0; a < WB_NUM; a++) begin : g_wa
        for (genvar b = a + 1; b < WB_NUM; b++) begin : g_wb
            a_no_collide: assert property (@(posedge clk) disable iff (!rst_n)
                !(wb[a].en && wb[b].en && (wb[a].idx != '0) && (wb[a].idx == wb[b].idx)));
        end
    end

endmodule

// File: reg_scoreboard.sv
`timescale 1ns/1ps

module reg_scoreboard
    import dispatch_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     issue_fire,
    input  logic [REG_IDX_WIDTH-1:0] issue_rd,
    input  logic                     issue_rd_en,
    input  wb_t                      wb [WB_NUM],
    output logic [REG_NUM-1:0]       lock
);

    logic [REG_NUM-1:0] release_vec;

    // any channel writing register i frees it
    always_comb begin
        release_vec = '0;
        for (int j = 0; j < WB_NUM; j++) begin
            if (wb[j].en) begin
                release_vec[wb[j].idx] = 1'b1;
            end
        end
    end

    // ====================
    // lock bits
    // ====================
    // x0 never locks
    assign lock[0] = 1'b0;

    for (genvar i = 1; i < REG_NUM; i++) begin : g_lock
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                lock[i] <= 1'b0;
            end else if (release_vec[i]) begin
                // clear wins over set
                lock[i] <= 1'b0;
            end else if (issue_fire && issue_rd_en && (issue_rd == REG_IDX_WIDTH'(i))) begin
                lock[i] <= 1'b1;
            end
        end
    end

    // a unit only writes back what was issued to it
    for (genvar j = 0; j < WB_NUM; j++) begin : g_chk
        a_wb_locked: assert property (@(posedge clk) disable iff (!rst_n)
            wb[j].en && (wb[j].idx != '0) |-> lock[wb[j].idx]);
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the dispatch testbench under verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_dispatch -f files.f \
    --Mdir obj_dir -o sim_dispatch > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_dispatch > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# verdict comes from the log
if grep -q "Some tests failed" "$log"; then
    exit 1
fi
exit 0

// File: tb_dispatch.sv
`timescale 1ns/1ps

module tb_dispatch
    import dispatch_pkg::*;
();

    localparam int N_ITEMS    = 200;
    // per item: up to 4 cycles of write-back wait plus random ready and fetch gaps
    localparam int MAX_CYCLES = 64 + N_ITEMS * 24;

    logic                clk;
    logic                rst_n;
    logic                fetch_vld;
    fetch_t              fetch;
    logic                fetch_rdy;
    issue_t              issue;
    logic [UNIT_NUM-1:0] issue_vld;
    logic [UNIT_NUM-1:0] issue_rdy;
    logic                trap_en;
    logic [31:0]         trap_cause;
    wb_t                 wb [WB_NUM];
    logic [63:0]         instret;

    // stimulus, last two opcodes are illegal
    fetch_t     items [N_ITEMS];
    logic [4:0] op_list [13] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
                                 OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_MISC_MEM, OPC_SYSTEM,
                                 5'b00010, 5'b11110};

    // reference state
    logic [REG_WIDTH-1:0] ref_regs [REG_NUM];
    logic [REG_NUM-1:0]   pending;
    logic [WB_NUM-1:0]    busy;
    int                   due [WB_NUM];
    logic [4:0]           wb_rd [WB_NUM];
    logic [31:0]          wb_data [WB_NUM];
    logic [63:0]          fetch_count;
    logic                 fetch_took;
    int                   fidx;
    int                   iidx;
    int                   cycle = 0;
    int                   err_cnt = 0;
    bit                   timed_out;

    fetch_t               exp_item;
    logic [UNIT_NUM-1:0]  exp_vld;
    logic [31:0]          ref_rs1;
    logic [31:0]          ref_rs2;
    issue_t               held_view;
    logic                 issue_fire;
    logic                 stalled;
    logic                 fetch_fire;
    logic                 fetch_hazard;

    dispatch_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_vld  (fetch_vld),
        .fetch      (fetch),
        .fetch_rdy  (fetch_rdy),
        .issue      (issue),
        .issue_vld  (issue_vld),
        .issue_rdy  (issue_rdy),
        .trap_en    (trap_en),
        .trap_cause (trap_cause),
        .wb         (wb),
        .instret    (instret)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ====================
    // opcode rules
    // ====================
    function automatic logic [2:0] unit_of(logic [31:0] i);
        case (i[6:2])
            OPC_OP:              return i[25] ? UNIT_MEXT : UNIT_ALU;
            OPC_LOAD, OPC_STORE: return UNIT_LSU;
            OPC_SYSTEM:          return UNIT_CSR;
            OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_OP_IMM, OPC_MISC_MEM:
                return UNIT_ALU;
            default:             return UNIT_SPU;
        endcase
    endfunction

    function automatic logic writes_rd(logic [31:0] i);
        if (unit_of(i) == UNIT_SPU || i[6:2] == OPC_BRANCH || i[6:2] == OPC_STORE) begin
            return 1'b0;
        end
        // ecall and friends
        return !(i[6:2] == OPC_SYSTEM && i[14:12] == 3'b000);
    endfunction

    function automatic logic uses_rs1(logic [31:0] i);
        return !(i[6:2] == OPC_LUI || i[6:2] == OPC_AUIPC || i[6:2] == OPC_JAL);
    endfunction

    function automatic logic uses_rs2(logic [31:0] i);
        return i[6:2] == OPC_OP || i[6:2] == OPC_STORE || i[6:2] == OPC_BRANCH;
    endfunction

    // rv32 immediate formats, zero for r-type and illegal
    function automatic logic [31:0] imm_of(logic [31:0] i);
        case (i[6:2])
            OPC_LUI, OPC_AUIPC:
                return {i[31:12], 12'b0};
            OPC_JAL:
                return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            OPC_JALR, OPC_OP_IMM, OPC_MISC_MEM, OPC_LOAD, OPC_SYSTEM:
                return {{20{i[31]}}, i[31:20]};
            OPC_BRANCH:
                return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            OPC_STORE:
                return {{20{i[31]}}, i[31:25], i[11:7]};
            default:
                return 32'd0;
        endcase
    endfunction

    // write-back channel order lsu, alu, csr, mext
    function automatic logic [1:0] channel_of(logic [2:0] u);
        case (u)
            UNIT_LSU:  return 2'd0;
            UNIT_CSR:  return 2'd2;
            UNIT_MEXT: return 2'd3;
            default:   return 2'd1;
        endcase
    endfunction

    task automatic note_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        err_cnt++;
        $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic note_failure(string what);
        err_cnt++;
        $display("error at %0t: %s", $time, what);
    endtask

    // ====================
    // expected values
    // ====================
    assign issue_fire = |(issue_vld & issue_rdy);
    assign stalled    = (issue_vld != '0) && !issue_fire;
    assign fetch_fire = fetch_vld && fetch_rdy;

    always_comb begin
        exp_item = (iidx < N_ITEMS) ? items[iidx] : '0;
        exp_vld  = '0;
        exp_vld[unit_of(exp_item.inst)] = 1'b1;
        // x0 reads zero
        ref_rs1 = (exp_item.inst[19:15] == 5'd0) ? '0 : ref_regs[exp_item.inst[19:15]];
        ref_rs2 = (exp_item.inst[24:20] == 5'd0) ? '0 : ref_regs[exp_item.inst[24:20]];
        fetch_hazard = (uses_rs1(fetch.inst) && pending[fetch.inst[19:15]])
                    || (uses_rs2(fetch.inst) && pending[fetch.inst[24:20]])
                    || (writes_rd(fetch.inst) && pending[fetch.inst[11:7]]);
        // operand slots of unused fields may follow unrelated write-backs
        held_view = issue;
        if (!uses_rs1(issue.inst)) begin
            held_view.rs1_val = '0;
        end
        if (!uses_rs2(issue.inst)) begin
            held_view.rs2_val = '0;
        end
    end

    // ====================
    // monitor and unit model
    // ====================
    always @(posedge clk) begin : monitor
        logic [1:0] ch;
        cycle      <= cycle + 1;
        fetch_took <= fetch_fire;
        if (!rst_n) begin
            fidx        <= 0;
            iidx        <= 0;
            fetch_count <= '0;
            pending     <= '0;
            busy        <= '0;
            for (int r = 0; r < REG_NUM; r++) begin
                ref_regs[r] <= '0;
            end
            for (int c = 0; c < WB_NUM; c++) begin
                due[c]     <= 0;
                wb_rd[c]   <= '0;
                wb_data[c] <= '0;
            end
        end else begin
            for (int c = 0; c < WB_NUM; c++) begin
                if (wb[c].en) begin
                    busy[c]            <= 1'b0;
                    pending[wb[c].idx] <= 1'b0;
                    if (wb[c].idx != '0) begin
                        ref_regs[wb[c].idx] <= wb[c].data;
                    end
                end
            end
            // lock from accept on, so the item waiting in decode counts too
            if (fetch_fire) begin
                fidx        <= fidx + 1;
                fetch_count <= fetch_count + 64'd1;
                if (writes_rd(fetch.inst) && fetch.inst[11:7] != 5'd0) begin
                    pending[fetch.inst[11:7]] <= 1'b1;
                end
            end
            if (issue_fire) begin
                iidx <= iidx + 1;
                if (issue.rd_en) begin
                    // result comes back 1 to 4 cycles later
                    ch          = channel_of(unit_of(issue.inst));
                    busy[ch]    <= 1'b1;
                    due[ch]     <= cycle + 1 + int'($urandom % 4);
                    wb_rd[ch]   <= issue.rd;
                    wb_data[ch] <= $urandom;
                end
            end
        end
    end

    // falling edge drive, a unit with a result in flight stays not ready
    task automatic drive_inputs();
        for (int u = 0; u < UNIT_NUM; u++) begin
            if (u != int'(UNIT_SPU) && busy[channel_of(3'(u))]) begin
                issue_rdy[u] = 1'b0;
            end else begin
                issue_rdy[u] = ($urandom % 4) != 0;
            end
        end
        for (int c = 0; c < WB_NUM; c++) begin
            wb[c].en   = busy[c] && (cycle >= due[c]);
            wb[c].idx  = wb_rd[c];
            wb[c].data = wb_data[c];
        end
        // valid stays up until taken
        if (!fetch_vld || fetch_took) begin
            fetch_vld = (fidx < N_ITEMS) && (($urandom % 8) != 0);
        end
        fetch = (fidx < N_ITEMS) ? items[fidx] : '0;
    endtask

    // ====================
    // checks
    // ====================
    a_route: assert property (@(posedge clk) disable iff (!rst_n)
        issue_vld != '0 |-> issue_vld == exp_vld)
        else note_mismatch("issue_vld", 64'($sampled(issue_vld)), 64'($sampled(exp_vld)));
    a_inst: assert property (@(posedge clk) disable iff (!rst_n)
        issue_fire |-> issue.inst == exp_item.inst)
        else note_mismatch("issue.inst", 64'($sampled(issue.inst)), 64'($sampled(exp_item.inst)));
    a_pc: assert property (@(posedge clk) disable iff (!rst_n)
        issue_fire |-> issue.pc == exp_item.pc)
        else note_mismatch("issue.pc", 64'($sampled(issue.pc)), 64'($sampled(exp_item.pc)));
    a_tag: assert property (@(posedge clk) disable iff (!rst_n)
        issue_fire |-> issue.tag == exp_item.tag)
        else note_mismatch("issue.tag", 64'($sampled(issue.tag)), 64'($sampled(exp_item.tag)));
    a_rd_en: assert property (@(posedge clk) disable iff (!rst_n)
        issue_fire |-> issue.rd_en == writes_rd(exp_item.inst))
        else note_mismatch("issue.rd_en", 64'($sampled(issue.rd_en)),
                           64'(writes_rd($sampled(exp_item.inst))));
    a_imm: assert property (@(posedge clk) disable iff (!rst_n)
        issue_fire |-> issue.imm == imm_of(exp_item.inst))
        else note_mismatch("issue.imm", 64'($sampled(issue.imm)),
                           64'(imm_of($sampled(exp_item.inst))));
    a_rs1: assert property (@(posedge clk) disable iff (!rst_n)
        issue_fire && uses_rs1(exp_item.inst) |-> issue.rs1_val == ref_rs1)
        else note_mismatch("issue.rs1_val", 64'($sampled(issue.rs1_val)), 64'($sampled(ref_rs1)));
    a_rs2: assert property (@(posedge clk) disable iff (!rst_n)
        issue_fire && uses_rs2(exp_item.inst) |-> issue.rs2_val == ref_rs2)
        else note_mismatch("issue.rs2_val", 64'($sampled(issue.rs2_val)), 64'($sampled(ref_rs2)));
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stalled |=> $stable(held_view) && $stable(issue_vld))
        else note_failure("issue payload or valid changed while the unit held ready low");
    a_hazard: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_fire |-> !fetch_hazard)
        else note_failure("fetch accepted while one of its registers awaits a write-back");
    a_resume: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_vld && pending == '0 && issue_vld == '0 |-> fetch_rdy)
        else note_failure("fetch refused with an empty stage and no write-back outstanding");
    a_trap_en: assert property (@(posedge clk) disable iff (!rst_n)
        issue_vld[UNIT_SPU] |-> trap_en)
        else note_mismatch("trap_en", 64'($sampled(trap_en)), 64'd1);
    a_cause: assert property (@(posedge clk) disable iff (!rst_n)
        issue_vld[UNIT_SPU] |-> trap_cause == 32'd2)
        else note_mismatch("trap_cause", 64'($sampled(trap_cause)), 64'd2);
    a_instret: assert property (@(posedge clk) disable iff (!rst_n)
        instret == fetch_count)
        else note_mismatch("instret", $sampled(instret), $sampled(fetch_count));

    // ====================
    // main sequence
    // ====================
    initial begin : stimulus
        logic [31:0] r;
        int          sel;
        void'($urandom(29593));
        // registers kept to x0..x7 so hazards come often
        for (int k = 0; k < N_ITEMS; k++) begin
            r   = $urandom;
            sel = $urandom % 13;
            items[k].inst = {r[31:25], 2'b00, r[22:20], 2'b00, r[17:15], r[14:12],
                             2'b00, r[9:7], op_list[sel], 2'b11};
            items[k].pc   = 32'h1000 + 32'(4 * k);
            items[k].tag  = 5'(k);
        end
        rst_n     = 1'b0;
        fetch_vld = 1'b0;
        fetch     = '0;
        issue_rdy = '0;
        timed_out = 1'b0;
        for (int c = 0; c < WB_NUM; c++) begin
            wb[c] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        a_reset_count: assert (instret == 64'd0)
            else note_mismatch("instret", instret, 64'd0);
        a_reset_vld: assert (issue_vld == '0)
            else note_mismatch("issue_vld", 64'(issue_vld), 64'd0);
        // decoder opens one edge after reset
        repeat (2) @(negedge clk);
        while (!((iidx == N_ITEMS) && (busy == '0)) && (cycle < MAX_CYCLES)) begin
            drive_inputs();
            @(negedge clk);
        end
        if (cycle >= MAX_CYCLES) begin
            timed_out = 1'b1;
            $display("timeout: %0d of %0d instructions issued after %0d cycles",
                     iidx, N_ITEMS, cycle);
        end
        a_final_count: assert (instret == 64'(N_ITEMS))
            else note_mismatch("instret", instret, 64'(N_ITEMS));
        $display("closing report: %0d check errors, %0d timeouts", err_cnt, int'(timed_out));
        if (err_cnt == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
